/* source/rv_pkg.sv */
// RV32I subset core package with widths, opcodes, ALU codes and pipeline structs
package rv_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN      = 32;  // Data word
    localparam int REG_IDX_W = 5;   // Register index
    localparam int NUM_REGS  = 32;  // x0 to x31
    localparam int OPC_W     = 7;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPC_W-1:0]     opcode_t;

    // ----------------------------------------
    // Opcodes and function codes
    // ----------------------------------------
    localparam opcode_t OPC_OP     = 7'b0110011;  // R-type ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // I-type ALU
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_STORE  = 7'b0100011;  // Only SW decoded

    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;  // SRL and SRA share it
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_SW   = 3'b010;  // Word store

    localparam int F7_ALT_BIT = 5;  // funct7 bit picking SUB or SRA

    // ALU operation
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // ----------------------------------------
    // Pipeline structs
    // ----------------------------------------
    typedef struct packed {
        logic    reg_write;    // Never set for rd == x0
        logic    mem_write;    // Store
        logic    alu_src_imm;  // B from immediate
        logic    zero_a;       // A forced to zero, LUI
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;
    } dec_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
        xlen_t data;
    } st_t;

endpackage

/* source/rv_decode.sv */
// Instruction decoder, turns an RV32I subset word into control bits, indices and an immediate
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::xlen_t instr,
    input  logic          valid,
    output rv_pkg::dec_t  dec
);

    // ----------------------------------------
    // Field extraction
    // ----------------------------------------
    rv_pkg::opcode_t  opcode;
    rv_pkg::reg_idx_t rd;
    logic [2:0]       funct3;
    logic             alt;     // SUB / SRA select

    rv_pkg::xlen_t imm_i;      // I form, sign extended
    rv_pkg::xlen_t imm_sh;     // Shift amount, zero extended
    rv_pkg::xlen_t imm_s;      // S form
    rv_pkg::xlen_t imm_u;      // U form

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign alt    = instr[25 + rv_pkg::F7_ALT_BIT];

    assign imm_i  = {{(rv_pkg::XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_sh = {{(rv_pkg::XLEN-5){1'b0}}, instr[24:20]};
    assign imm_s  = {{(rv_pkg::XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u  = {instr[31:12], 12'd0};  // Low twelve bits cleared

    // ----------------------------------------
    // Control generation
    // ----------------------------------------
    always_comb begin
        dec     = '0;            // Bubble by default
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = rd;
        dec.imm = imm_i;

        case (opcode)
            rv_pkg::OPC_OP: begin
                dec.ctrl.reg_write = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD:  dec.ctrl.alu_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLL:  dec.ctrl.alu_op = rv_pkg::ALU_SLL;
                    rv_pkg::F3_SLT:  dec.ctrl.alu_op = rv_pkg::ALU_SLT;
                    rv_pkg::F3_SLTU: dec.ctrl.alu_op = rv_pkg::ALU_SLTU;
                    rv_pkg::F3_XOR:  dec.ctrl.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SRL:  dec.ctrl.alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::F3_OR:   dec.ctrl.alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND:  dec.ctrl.alu_op = rv_pkg::ALU_AND;
                endcase
            end

            rv_pkg::OPC_OP_IMM: begin
                dec.ctrl.reg_write   = 1'b1;
                dec.ctrl.alu_src_imm = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD:  dec.ctrl.alu_op = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLL: begin
                        dec.ctrl.alu_op = rv_pkg::ALU_SLL;   // SLLI
                        dec.imm         = imm_sh;
                    end
                    rv_pkg::F3_SLT:  dec.ctrl.alu_op = rv_pkg::ALU_SLT;   // SLTI
                    rv_pkg::F3_SLTU: dec.ctrl.alu_op = rv_pkg::ALU_SLTU;  // SLTIU
                    rv_pkg::F3_XOR:  dec.ctrl.alu_op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SRL: begin
                        // SRAI carries funct7 in the upper immediate bits
                        dec.ctrl.alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        dec.imm         = imm_sh;
                    end
                    rv_pkg::F3_OR:   dec.ctrl.alu_op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND:  dec.ctrl.alu_op = rv_pkg::ALU_AND;
                endcase
            end

            rv_pkg::OPC_LUI: begin
                // 0 + imm through the adder
                dec.ctrl.reg_write   = 1'b1;
                dec.ctrl.alu_src_imm = 1'b1;
                dec.ctrl.zero_a      = 1'b1;
                dec.imm              = imm_u;
            end

            rv_pkg::OPC_STORE: begin
                if (funct3 == rv_pkg::F3_SW) begin  // SB, SH dropped to bubble
                    dec.ctrl.mem_write   = 1'b1;
                    dec.ctrl.alu_src_imm = 1'b1;
                    dec.imm              = imm_s;
                end
            end

            default: ;  // Unknown opcode, bubble
        endcase

        if (!valid) begin
            dec.ctrl = '0;
        end
        if (rd == '0) begin
            dec.ctrl.reg_write = 1'b0;  // x0 is never written
        end
    end

endmodule

/* source/rv_regfile.sv */
// Register file, 32 x 32 with two combinational read ports and a write-through write port
`timescale 1ns/10ps

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::xlen_t    rdata1,
    output rv_pkg::xlen_t    rdata2,
    input  logic             we,
    input  rv_pkg::reg_idx_t wa,
    input  rv_pkg::xlen_t    wdata
);

    rv_pkg::xlen_t regs [rv_pkg::NUM_REGS];  // Entry 0 stays zero
    logic          hit1;
    logic          hit2;

    // Write port, x0 ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wdata;
        end
    end

    // Same-cycle write is visible on the read side
    assign hit1 = we && (wa == rs1) && (rs1 != '0);
    assign hit2 = we && (wa == rs2) && (rs2 != '0);

    assign rdata1 = hit1 ? wdata : regs[rs1];
    assign rdata2 = hit2 ? wdata : regs[rs2];

endmodule

/* source/rv_alu.sv */
// Combinational ALU for the ten RV32I integer operations
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t   y
);

    logic [4:0] shamt;     // Low five bits of b
    logic       lt_s;      // Signed compare
    logic       lt_u;      // Unsigned compare

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  y = a + b;
            rv_pkg::ALU_SUB:  y = a - b;
            rv_pkg::ALU_SLL:  y = a << shamt;
            rv_pkg::ALU_SLT:  y = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU: y = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            rv_pkg::ALU_XOR:  y = a ^ b;
            rv_pkg::ALU_SRL:  y = a >> shamt;
            rv_pkg::ALU_SRA:  y = rv_pkg::xlen_t'($signed(a) >>> shamt);  // Sign fill
            rv_pkg::ALU_OR:   y = a | b;
            rv_pkg::ALU_AND:  y = a & b;
            default:          y = '0;  // Unused encodings
        endcase
    end

endmodule

/* source/rv_core.sv */
// Five-stage in-order RV32I subset core with full forwarding, writeback and store ports
`timescale 1ns/10ps

module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          instr_valid,
    input  rv_pkg::xlen_t instr,
    output rv_pkg::wb_t   wb,
    output rv_pkg::st_t   st
);

    // Operand select, EX/MEM first, then MEM/WB, then the value read in ID
    function automatic rv_pkg::xlen_t fwd_sel(
        input rv_pkg::reg_idx_t idx,
        input rv_pkg::xlen_t    stored,
        input rv_pkg::wb_t      ex_res,
        input rv_pkg::wb_t      mem_res
    );
        rv_pkg::xlen_t val;
        if (ex_res.valid && (ex_res.rd == idx) && (idx != '0)) begin
            val = ex_res.data;
        end else if (mem_res.valid && (mem_res.rd == idx) && (idx != '0)) begin
            val = mem_res.data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    // Pipeline registers
    logic          ifid_valid;
    rv_pkg::xlen_t ifid_instr;
    rv_pkg::dec_t  idex_dec;
    rv_pkg::xlen_t idex_rdata1;
    rv_pkg::xlen_t idex_rdata2;
    rv_pkg::wb_t   exmem_wb;     // Result headed for writeback
    rv_pkg::st_t   exmem_st;     // Store event
    rv_pkg::wb_t   memwb_wb;

    // ID and EX nets
    rv_pkg::dec_t  id_dec;
    rv_pkg::xlen_t rf_rdata1;
    rv_pkg::xlen_t rf_rdata2;
    rv_pkg::xlen_t ex_rs1_val;   // Forwarded rs1
    rv_pkg::xlen_t ex_rs2_val;   // Forwarded rs2, also store data
    rv_pkg::xlen_t alu_a;
    rv_pkg::xlen_t alu_b;
    rv_pkg::xlen_t alu_y;

    // ----------------------------------------
    // IF/ID, one instruction per cycle
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifid_valid <= 1'b0;
        end else begin
            ifid_valid <= instr_valid;  // Low enters as a bubble
        end
    end

    always_ff @(posedge clk) begin
        ifid_instr <= instr;
    end

    // ----------------------------------------
    // ID stage
    // ----------------------------------------
    rv_decode u_decode (
        .instr (ifid_instr),
        .valid (ifid_valid),
        .dec   (id_dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (id_dec.rs1),
        .rs2    (id_dec.rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (memwb_wb.valid),  // Written at the edge after wb shows
        .wa     (memwb_wb.rd),
        .wdata  (memwb_wb.data)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_dec.ctrl.reg_write <= 1'b0;
            idex_dec.ctrl.mem_write <= 1'b0;
        end else begin
            idex_dec    <= id_dec;
            idex_rdata1 <= rf_rdata1;
            idex_rdata2 <= rf_rdata2;
        end
    end

    // ----------------------------------------
    // EX stage
    // ----------------------------------------
    assign ex_rs1_val = fwd_sel(idex_dec.rs1, idex_rdata1, exmem_wb, memwb_wb);
    assign ex_rs2_val = fwd_sel(idex_dec.rs2, idex_rdata2, exmem_wb, memwb_wb);

    assign alu_a = idex_dec.ctrl.zero_a ? '0 : ex_rs1_val;             // LUI adds to zero
    assign alu_b = idex_dec.ctrl.alu_src_imm ? idex_dec.imm : ex_rs2_val;

    rv_alu u_alu (
        .op (idex_dec.ctrl.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exmem_wb.valid <= 1'b0;
            exmem_st.valid <= 1'b0;
        end else begin
            exmem_wb.valid <= idex_dec.ctrl.reg_write;
            exmem_wb.rd    <= idex_dec.rd;
            exmem_wb.data  <= alu_y;
            exmem_st.valid <= idex_dec.ctrl.mem_write;
            exmem_st.addr  <= alu_y;        // rs1 + S immediate
            exmem_st.data  <= ex_rs2_val;
        end
    end

    // ----------------------------------------
    // MEM/WB
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memwb_wb.valid <= 1'b0;
        end else begin
            memwb_wb <= exmem_wb;  // No load path, result passes straight on
        end
    end

    // Fire-and-forget outputs
    assign st = exmem_st;
    assign wb = memwb_wb;

endmodule

/* dv/rv_core_props.sv */
// Bound checks on the writeback and store ports of the RV32I subset core
`timescale 1ns/10ps

module rv_core_props (
    input logic          clk,
    input logic          rst_n,
    input logic          instr_valid,
    input rv_pkg::xlen_t instr,
    input rv_pkg::wb_t   wb,
    input rv_pkg::st_t   st
);

    logic wb_issue;  // Accepted instruction that must reach writeback

    assign wb_issue = instr_valid && (instr[11:7] != '0) &&
                      ((instr[6:0] == rv_pkg::OPC_OP) ||
                       (instr[6:0] == rv_pkg::OPC_OP_IMM) ||
                       (instr[6:0] == rv_pkg::OPC_LUI));

    // ----------------------------------------
    // Writeback port
    // ----------------------------------------
    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> (wb.rd != '0)) else $error("writeback targets x0");

    // Four edges from acceptance to wb.valid, in both directions
    a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(wb_issue, 4) |-> wb.valid) else $error("writeback missing four cycles after issue");
    a_wb_source: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> $past(wb_issue, 4)) else $error("writeback without a matching issue");

    // ----------------------------------------
    // No X on outputs
    // ----------------------------------------
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({wb.valid, st.valid})) else $error("output valid is unknown");
    a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> !$isunknown(wb)) else $error("writeback payload is unknown");
    a_st_known: assert property (@(posedge clk) disable iff (!rst_n)
        st.valid |-> !$isunknown(st)) else $error("store payload is unknown");

endmodule

bind rv_core rv_core_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb),
    .st          (st)
);

/* dv/tb_rv_core.sv */
// Testbench for the RV32I subset core, random stimulus against a reference register model
`timescale 1ns/10ps

module tb_rv_core;

    localparam int N_IDLE      = 5;
    localparam int N_DIRECTED  = 11;
    localparam int N_RANDOM    = 2000;
    localparam int N_INSTR     = N_IDLE + N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_NS = N_INSTR * 10 + 200;

    typedef struct packed {
        logic             is_store;
        rv_pkg::reg_idx_t rd;
        rv_pkg::xlen_t    addr;
        rv_pkg::xlen_t    data;
    } event_t;

    logic          clk;
    logic          rst_n;
    logic          instr_valid;
    rv_pkg::xlen_t instr;
    rv_pkg::wb_t   wb;
    rv_pkg::st_t   st;

    rv_pkg::xlen_t ref_regs [32];  // Architectural state of the model
    event_t        exp_q [$];      // Expected events in program order
    logic [31:0]   rng_state = 32'h5aff_e7ae;
    rv_pkg::xlen_t rnd_ins;
    logic          rnd_valid;

    rv_core u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .st          (st)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Encoders and random source
    // ----------------------------------------
    function automatic rv_pkg::xlen_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                            input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                            input rv_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::xlen_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                            input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
        return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::xlen_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    function automatic rv_pkg::xlen_t enc_s(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
                                            input rv_pkg::reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};  // SW
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Mostly x0 to x3, so dependencies come close together
    function automatic rv_pkg::reg_idx_t pick_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[3:2] != 2'b00) ? {3'b000, r[1:0]} : r[8:4];
    endfunction

    task automatic gen_random(output rv_pkg::xlen_t ins, output logic valid);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        r     = next_rand();
        f3    = r[6:4];
        valid = 1'b1;
        f7    = (r[7] && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
        if (r[3:0] < 4'd5) begin
            ins = enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg());
        end else if (r[3:0] < 4'd10) begin
            if ((f3 == 3'b001) || (f3 == 3'b101)) begin
                imm = {(f3 == 3'b101) ? f7 : 7'h00, r[12:8]};  // Random shamt
            end else begin
                imm = r[31:20];
            end
            ins = enc_i(imm, pick_reg(), f3, pick_reg());
        end else if (r[3:0] < 4'd12) begin
            ins = enc_u(r[31:12], pick_reg());
        end else if (r[3:0] < 4'd14) begin
            ins = enc_s(r[31:20], pick_reg(), pick_reg());
        end else if (r[3:0] == 4'd14) begin
            ins = {r[31:7], 7'b1101111};  // JAL is outside the subset
        end else begin
            ins   = r;                    // Junk on the bus
            valid = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic rv_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
        logic signed [31:0] sra;
        rv_pkg::xlen_t      y;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'b000:  y = alt ? a - b : a + b;
            3'b001:  y = a << b[4:0];
            3'b010:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  y = (a < b) ? 32'd1 : 32'd0;
            3'b100:  y = a ^ b;
            3'b101:  y = alt ? sra : a >> b[4:0];
            3'b110:  y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    task automatic model_exec(input rv_pkg::xlen_t ins);
        logic [2:0]    f3;
        rv_pkg::xlen_t a;
        rv_pkg::xlen_t b;
        rv_pkg::xlen_t imm;
        logic          writes;
        event_t        ev;
        f3     = ins[14:12];
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        imm    = {{20{ins[31]}}, ins[31:20]};
        writes = 1'b1;
        ev     = '0;
        ev.rd  = ins[11:7];
        case (ins[6:0])
            rv_pkg::OPC_OP:     ev.data = alu_ref(f3, ins[30], a, b);
            rv_pkg::OPC_OP_IMM: ev.data = alu_ref(f3, (f3 == 3'b101) && ins[30], a, imm);
            rv_pkg::OPC_LUI:    ev.data = {ins[31:12], 12'd0};
            rv_pkg::OPC_STORE: begin
                writes      = 1'b0;
                ev.is_store = (f3 == 3'b010);
                ev.addr     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                ev.data     = b;
            end
            default: writes = 1'b0;  // Not in the subset
        endcase
        if (writes && (ev.rd != '0)) begin
            ref_regs[ev.rd] = ev.data;
            exp_q.push_back(ev);
        end else if (ev.is_store) begin
            exp_q.push_back(ev);
        end
    endtask

    // Drive one slot 1 ns after the edge
    task automatic issue(input rv_pkg::xlen_t ins, input logic valid);
        @(posedge clk);
        #1;
        instr_valid = valid;
        instr       = ins;
        if (valid) begin
            model_exec(ins);
        end
    endtask

    // ----------------------------------------
    // Output checks
    // ----------------------------------------
    task automatic report_value(input string field, input rv_pkg::xlen_t got,
                                input rv_pkg::xlen_t want);
        $display("FAILED at %0d ns: %s is %h, expected %h", $time, field, got, want);
        $display("Simulation failed");
        $fatal(1, "value mismatch on the DUT outputs");
    endtask

    task automatic stop_run(input string what);
        $display("At %0d ns the DUT produced a %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "unexpected event on the DUT outputs");
    endtask

    task automatic check_wb();
        event_t want;
        assert (exp_q.size() > 0) else stop_run("writeback event with nothing expected");
        want = exp_q.pop_front();
        assert (!want.is_store) else stop_run("writeback event where a store was due");
        assert (wb.rd == want.rd) else report_value("wb.rd", {27'd0, wb.rd}, {27'd0, want.rd});
        assert (wb.data == want.data) else report_value("wb.data", wb.data, want.data);
    endtask

    task automatic check_st();
        event_t want;
        assert (exp_q.size() > 0) else stop_run("store event with nothing expected");
        want = exp_q.pop_front();
        assert (want.is_store) else stop_run("store event where a writeback was due");
        assert (st.addr == want.addr) else report_value("st.addr", st.addr, want.addr);
        assert (st.data == want.data) else report_value("st.data", st.data, want.data);
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb.valid) check_wb();   // Older instruction first
            if (st.valid) check_st();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with events still outstanding", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        repeat (N_IDLE) issue('0, 1'b0);  // Idle ports after reset

        // Forwarding at distance 1, 2 and 3, then a store fed from the previous result
        issue(enc_u(20'habcde, 5'd1), 1'b1);
        issue(enc_u(20'h12345, 5'd0), 1'b1);                      // LUI to x0 gives no event
        issue(enc_i(12'h7ff, 5'd1, 3'b000, 5'd2), 1'b1);
        issue(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3), 1'b1);      // SUB
        issue(enc_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd1), 1'b1);      // SLT closes a chain of three
        issue('0, 1'b0);
        issue(enc_i({7'h20, 5'd4}, 5'd3, 3'b101, 5'd2), 1'b1);    // SRAI
        issue(enc_s(12'h804, 5'd2, 5'd1), 1'b1);
        issue(32'h0000_006f, 1'b1);                               // Unknown opcode
        issue(enc_r(7'h00, 5'd0, 5'd2, 3'b111, 5'd0), 1'b1);
        issue(enc_r(7'h00, 5'd2, 5'd0, 3'b100, 5'd3), 1'b1);      // x0 reads zero

        repeat (N_RANDOM) begin
            gen_random(rnd_ins, rnd_valid);
            issue(rnd_ins, rnd_valid);
        end
        @(posedge clk);
        #1 instr_valid = 1'b0;

        // Wait for the last expected event, then a few idle cycles for strays
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* all.f */
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_core.sv
dv/rv_core_props.sv
dv/tb_rv_core.sv

/* Makefile */
# Verilator build and run for the RV32I subset core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_rv_core \
		--Mdir obj_dir -o sim_tb_rv_core
	./obj_dir/sim_tb_rv_core

clean:
	rm -rf obj_dir
